//--- vlog.f
+incdir+design
design/rv_isa_pkg.sv
design/rv_ctrl_pkg.sv
design/control_unit.sv
design/instr_decode.sv
design/execute_unit.sv
design/result_stage.sv
design/rv_core.sv
test/rv_core_assert.sv
test/rv_core_tb.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - include_dirs:
      - design
    files:
      - design/rv_isa_pkg.sv
      - design/rv_ctrl_pkg.sv
      - design/control_unit.sv
      - design/instr_decode.sv
      - design/execute_unit.sv
      - design/result_stage.sv
      - design/rv_core.sv
  - target: test
    include_dirs:
      - design
    files:
      - test/rv_core_assert.sv
      - test/rv_core_tb.sv

//--- test/rv_core_tb.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_core_tb;

  localparam int MAX_CYCLES = 2000; // about 60 instructions of 4 cycles, six resets and margin.
  localparam logic [6:0] OP_CUSTOM = 7'b0001011; // outside the subset, runs as r-type.

  logic                  clk;
  logic                  rst_n;
  logic [31:0]           instr;
  logic [31:0]           d_mem_rdata;
  logic [31:0]           pc;
  rv_isa_pkg::dmem_req_t dmem_req;
  logic                  retire;

  logic [31:0]           imem [64];
  logic [31:0]           dmem [256];
  logic [31:0]           exp_pc_q [$];
  rv_isa_pkg::dmem_req_t exp_st_q [$];
  string                 test_name;
  int                    seed;
  int                    cycles;
  int                    retired;
  int                    since_retire;
  logic                  checking;

  rv_core DUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr       (instr),
    .d_mem_rdata (d_mem_rdata),
    .pc          (pc),
    .dmem_req    (dmem_req),
    .retire      (retire)
  );

  always #20 clk = ~clk;

  assign instr       = imem[pc[7:2]];
  assign d_mem_rdata = dmem[dmem_req.addr[9:2]];

  always @(posedge clk) begin
    if (dmem_req.we) dmem[dmem_req.addr[9:2]] <= dmem_req.wdata;
    if (rst_n) since_retire = since_retire + 1;
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles.", MAX_CYCLES);
      fail_run();
    end
  end

  // stores and retires are sampled half a cycle after the edge that set them.
  always @(negedge clk) begin
    if (checking && dmem_req.we) begin
      if (exp_st_q.size() == 0) begin
        $display("Error %s: store of %h to %h where none was expected.", test_name,
                 dmem_req.wdata, dmem_req.addr);
        fail_run();
      end
      compare_dmem_req(exp_st_q.pop_front(), dmem_req);
    end
    if (checking && retire) begin
      if (since_retire != 4 || exp_pc_q.size() == 0) begin
        $display("Error %s: retire out of step, %0d cycles since the last one.", test_name,
                 since_retire);
        fail_run();
      end
      compare_pc(exp_pc_q.pop_front(), pc);
      since_retire = 0;
      retired++;
    end
  end

  task automatic fail_run();
    $display("Verification failed");
    $fatal(1, "stopped at the first error.");
  endtask

  task automatic compare_dmem_req(input rv_isa_pkg::dmem_req_t exp,
                                  input rv_isa_pkg::dmem_req_t act);
    if (act !== exp) begin
      $display("Error %s: expected we=%0b addr=%h wdata=%h, actual we=%0b addr=%h wdata=%h",
               test_name, exp.we, exp.addr, exp.wdata, act.we, act.addr, act.wdata);
      fail_run();
    end
  endtask

  task automatic compare_pc(input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("Error %s: expected pc %h, actual pc %h", test_name, exp, act);
      fail_run();
    end
  endtask

  function automatic logic [31:0] addi_instr(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, rv_isa_pkg::OP_IMM};
  endfunction

  function automatic logic [31:0] lw_instr(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
    return {imm, rs1, 3'b010, rd, rv_isa_pkg::OP_LOAD};
  endfunction

  function automatic logic [31:0] sw_instr(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_isa_pkg::OP_STORE};
  endfunction

  function automatic logic [31:0] branch_instr(logic ne, logic [4:0] rs1, logic [4:0] rs2,
                                               logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, 2'b00, ne, off[4:1], off[11], rv_isa_pkg::OP_BRANCH};
  endfunction

  function automatic logic [31:0] alu_instr(logic sub, logic [4:0] rd, logic [4:0] rs1,
                                            logic [4:0] rs2, logic [6:0] op);
    return {1'b0, sub, 5'b00000, rs2, rs1, 3'b000, rd, op};
  endfunction

  task automatic fill_memories();
    for (int i = 0; i < 64; i++) imem[i] = addi_instr(5'd0, 5'd0, 12'(i * 4));
    for (int i = 0; i < 256; i++) dmem[i] = 32'hc0de_0000 | (i << 2);
  endtask

  // executes n instructions of the subset and records each pc and each store.
  task automatic run_model(input int n);
    logic [31:0] regs [32];
    logic [31:0] mem [256];
    logic [31:0] ins, a, b, mpc, res, addr, next_pc;
    logic        wr;
    mem = dmem;
    for (int i = 0; i < 32; i++) regs[i] = '0;
    mpc = `RV_RESET_PC;
    exp_pc_q.delete();
    exp_st_q.delete();
    for (int k = 0; k < n; k++) begin
      ins = imem[mpc[7:2]];
      a = regs[ins[19:15]];
      b = regs[ins[24:20]];
      wr = 1'b1;
      res = '0;
      next_pc = mpc + 32'd4;
      exp_pc_q.push_back(mpc);
      case (ins[6:0])
        rv_isa_pkg::OP_IMM:  res = a + {{20{ins[31]}}, ins[31:20]};
        rv_isa_pkg::OP_LOAD: begin
          addr = a + {{20{ins[31]}}, ins[31:20]};
          res = mem[addr[9:2]];
        end
        rv_isa_pkg::OP_STORE: begin
          wr = 1'b0;
          addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
          exp_st_q.push_back('{we: 1'b1, addr: addr, wdata: b});
          mem[addr[9:2]] = b;
        end
        rv_isa_pkg::OP_BRANCH: begin
          wr = 1'b0;
          if ((a == b) != ins[12]) begin // funct3 bit 0 turns beq into bne.
            next_pc = mpc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
          end
        end
        default: res = ins[30] ? a - b : a + b; // unknown opcodes act as r-type.
      endcase
      if (wr && ins[11:7] != 5'd0) regs[ins[11:7]] = res;
      mpc = next_pc;
    end
  endtask

  task automatic start_test(input string name);
    @(negedge clk);
    rst_n = 1'b0;
    checking = 1'b0;
    test_name = name;
    fill_memories();
  endtask

  // holds reset for 16 cycles, then runs until n instructions have retired.
  task automatic run_program(input int n);
    rst_n = 1'b0;
    checking = 1'b0;
    run_model(n);
    repeat (16) begin
      @(negedge clk);
      if (dmem_req.we !== 1'b0 || retire !== 1'b0 || pc !== `RV_RESET_PC) begin
        $display("Error %s: a strobe is active or pc is not at reset value in reset.",
                 test_name);
        fail_run();
      end
    end
    retired = 0;
    since_retire = 1; // the release cycle is the first fetch.
    rst_n = 1'b1;
    checking = 1'b1;
    wait (retired == n);
    checking = 1'b0;
    if (exp_st_q.size() != 0) begin
      $display("Error %s: %0d expected stores never happened.", test_name, exp_st_q.size());
      fail_run();
    end
  endtask

  task automatic check_immediates();
    logic [11:0] imm;
    start_test("immediates");
    for (int i = 0; i < 8; i++) begin
      imm = (i == 0) ? 12'h800 : 12'($random(seed));
      imem[2 * i] = addi_instr(5'd5, 5'd5, imm);
      imem[2 * i + 1] = sw_instr(5'd5, 5'd0, 12'h100);
    end
    run_program(16);
  endtask

  task automatic check_register_ops();
    start_test("register_ops");
    imem[0] = addi_instr(5'd1, 5'd0, 12'd1234);
    imem[1] = addi_instr(5'd2, 5'd0, 12'hfb3);
    imem[2] = alu_instr(1'b0, 5'd3, 5'd1, 5'd2, rv_isa_pkg::OP_RTYPE);
    imem[3] = alu_instr(1'b1, 5'd4, 5'd1, 5'd2, rv_isa_pkg::OP_RTYPE);
    imem[4] = alu_instr(1'b1, 5'd6, 5'd2, 5'd1, OP_CUSTOM);
    imem[5] = alu_instr(1'b0, 5'd0, 5'd1, 5'd2, rv_isa_pkg::OP_RTYPE); // x0 stays zero.
    imem[6] = sw_instr(5'd3, 5'd0, 12'h000);
    imem[7] = sw_instr(5'd4, 5'd0, 12'h004);
    imem[8] = sw_instr(5'd6, 5'd0, 12'h008);
    imem[9] = sw_instr(5'd0, 5'd0, 12'h00c);
    run_program(10);
  endtask

  task automatic check_loads();
    start_test("loads");
    dmem[18] = 32'h8765_4321;
    imem[0] = addi_instr(5'd1, 5'd0, 12'h040);
    imem[1] = lw_instr(5'd2, 5'd1, 12'h008);
    imem[2] = lw_instr(5'd3, 5'd1, 12'hffc);
    imem[3] = sw_instr(5'd2, 5'd1, 12'h080);
    imem[4] = sw_instr(5'd3, 5'd1, 12'h084);
    run_program(5);
  endtask

  task automatic check_branches();
    start_test("branches");
    imem[0] = addi_instr(5'd1, 5'd0, 12'd5);
    imem[1] = addi_instr(5'd2, 5'd0, 12'd5);
    imem[2] = branch_instr(1'b0, 5'd1, 5'd2, 13'd12);   // taken, skips both stores.
    imem[3] = sw_instr(5'd1, 5'd0, 12'h200);
    imem[4] = sw_instr(5'd2, 5'd0, 12'h204);
    imem[5] = branch_instr(1'b1, 5'd1, 5'd2, 13'd8);
    imem[6] = addi_instr(5'd3, 5'd3, 12'd1);
    imem[7] = branch_instr(1'b1, 5'd3, 5'd2, 13'h1ffc); // loops back until x3 equals 5.
    imem[8] = branch_instr(1'b0, 5'd3, 5'd0, 13'd8);
    imem[9] = sw_instr(5'd3, 5'd0, 12'h208);
    run_program(16);
  endtask

  task automatic check_reset_rerun();
    start_test("reset_rerun");
    imem[0] = addi_instr(5'd1, 5'd0, 12'd100);
    imem[1] = addi_instr(5'd2, 5'd1, 12'hffd);
    imem[2] = sw_instr(5'd2, 5'd0, 12'h010);
    imem[3] = alu_instr(1'b0, 5'd3, 5'd1, 5'd2, rv_isa_pkg::OP_RTYPE);
    imem[4] = sw_instr(5'd3, 5'd0, 12'h014);
    imem[5] = alu_instr(1'b1, 5'd4, 5'd3, 5'd1, rv_isa_pkg::OP_RTYPE);
    imem[6] = sw_instr(5'd4, 5'd0, 12'h018);
    run_program(3);
    repeat (3) @(negedge clk); // reset lands in execute of the add.
    run_program(7);
  endtask

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    seed = 99599;
    cycles = 0;
    retired = 0;
    since_retire = 0;
    checking = 1'b0;
    test_name = "init";
    fill_memories();
    check_immediates();
    check_register_ops();
    check_loads();
    check_branches();
    check_reset_rerun();
    $display("Verification passed");
    $finish;
  end

endmodule

//--- test/rv_core_assert.sv
`timescale 1ns/1ps

module rv_core_assert (
  input logic               clk,
  input logic               rst_n,
  input rv_ctrl_pkg::ctrl_t ctrl,
  input logic               retire
);

  // every instruction passes four states, so three quiet cycles follow a retire.
  property retire_spacing;
    @(posedge clk) disable iff (!rst_n) retire |=> !retire [*3];
  endproperty

  assert property (retire_spacing)
    else $error("retire repeated within four cycles.");

  assert property (@(posedge clk) disable iff (!rst_n) !(ctrl.rf_we && ctrl.d_mem_we))
    else $error("register write and memory write active in the same cycle.");

  assert property (@(posedge clk) !rst_n |-> !(ctrl.rf_we || ctrl.d_mem_we || retire))
    else $error("write strobe or retire active while reset is held.");

endmodule

bind control_unit rv_core_assert u_rv_core_assert (
  .clk    (clk),
  .rst_n  (rst_n),
  .ctrl   (ctrl),
  .retire (retire)
);

//--- design/rv_core.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_core (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [31:0]           instr,
  input  logic [31:0]           d_mem_rdata,
  output logic [31:0]           pc,
  output rv_isa_pkg::dmem_req_t dmem_req,
  output logic                  retire
);

  rv_ctrl_pkg::ctrl_t   ctrl;
  rv_isa_pkg::opcode_e  opcode;
  rv_isa_pkg::decoded_t dec;
  logic [`RV_XLEN-1:0]  op_a, op_b, store_data;
  logic [`RV_XLEN-1:0]  rs1_data, rs2_data;
  logic [`RV_XLEN-1:0]  alu_result, branch_target;
  logic                 zero;

  control_unit u_control_unit (
    .clk    (clk),
    .rst_n  (rst_n),
    .opcode (opcode),
    .ctrl   (ctrl),
    .retire (retire)
  );

  instr_decode u_instr_decode (
    .clk        (clk),
    .rst_n      (rst_n),
    .instr      (instr),
    .ctrl       (ctrl),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .dec        (dec),
    .opcode     (opcode),
    .op_a       (op_a),
    .op_b       (op_b),
    .store_data (store_data)
  );

  execute_unit u_execute_unit (
    .ctrl          (ctrl),
    .dec           (dec),
    .op_a          (op_a),
    .op_b          (op_b),
    .pc            (pc),
    .alu_result    (alu_result),
    .zero          (zero),
    .sign          (),             // no instruction in the subset needs it.
    .branch_target (branch_target)
  );

  result_stage u_result_stage (
    .clk           (clk),
    .rst_n         (rst_n),
    .ctrl          (ctrl),
    .dec           (dec),
    .alu_result    (alu_result),
    .d_mem_rdata   (d_mem_rdata),
    .branch_target (branch_target),
    .zero          (zero),
    .rs1_data      (rs1_data),
    .rs2_data      (rs2_data),
    .pc            (pc)
  );

  // the address doubles as the load address during execute.
  assign dmem_req.we    = ctrl.d_mem_we;
  assign dmem_req.addr  = alu_result;
  assign dmem_req.wdata = store_data;

endmodule

//--- design/result_stage.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module result_stage (
  input  logic                 clk,
  input  logic                 rst_n,
  input  rv_ctrl_pkg::ctrl_t   ctrl,
  input  rv_isa_pkg::decoded_t dec,
  input  logic [31:0]          alu_result,
  input  logic [31:0]          d_mem_rdata,
  input  logic [31:0]          branch_target,
  input  logic                 zero,
  output logic [31:0]          rs1_data,
  output logic [31:0]          rs2_data,
  output logic [31:0]          pc
);

  logic [`RV_XLEN-1:0] regs [`RV_NREGS];
  logic [`RV_XLEN-1:0] wb_data;
  logic                taken;
  logic                taken_q;

  assign wb_data = ctrl.rf_src ? d_mem_rdata : alu_result;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `RV_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (ctrl.rf_we && dec.rd != 5'd0) begin
      regs[dec.rd] <= wb_data;
    end
  end

  assign rs1_data = (dec.rs1 == 5'd0) ? '0 : regs[dec.rs1];
  assign rs2_data = (dec.rs2 == 5'd0) ? '0 : regs[dec.rs2];

  // beq takes the branch on equal operands, bne on different ones.
  assign taken = dec.branch_ne ? !zero : zero;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      taken_q <= 1'b0;
    end else begin
      taken_q <= ctrl.pc_src & taken; // cleared again for every other state.
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= `RV_RESET_PC;
    end else if (ctrl.pc_update) begin
      pc <= taken_q ? branch_target : pc + 32'd4;
    end
  end

endmodule

//--- design/execute_unit.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module execute_unit (
  input  rv_ctrl_pkg::ctrl_t   ctrl,
  input  rv_isa_pkg::decoded_t dec,
  input  logic [31:0]          op_a,
  input  logic [31:0]          op_b,
  input  logic [31:0]          pc,
  output logic [31:0]          alu_result,
  output logic                 zero,
  output logic                 sign,
  output logic [31:0]          branch_target
);

  logic [`RV_XLEN-1:0] sum;
  logic [`RV_XLEN-1:0] diff;
  logic                do_sub;

  assign sum  = op_a + op_b;
  assign diff = op_a - op_b;

  always_comb begin
    case (ctrl.alu_cmd)
      rv_isa_pkg::ALU_REG:  do_sub = dec.funct7_5; // sub has funct7 = 0100000.
      rv_isa_pkg::ALU_ADD,
      rv_isa_pkg::ALU_ADDR: do_sub = 1'b0;
      rv_isa_pkg::ALU_CMP:  do_sub = 1'b1;
      default:              do_sub = 1'b0;
    endcase
  end

  assign alu_result = do_sub ? diff : sum;

  // flags follow the selected result.
  assign zero = (alu_result == '0);
  assign sign = alu_result[`RV_XLEN-1];

  assign branch_target = pc + dec.imm; // imm already carries the zero lsb.

endmodule

//--- design/instr_decode.sv
`timescale 1ns/1ps
`include "rv_params.svh"

module instr_decode (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [31:0]          instr,
  input  rv_ctrl_pkg::ctrl_t   ctrl,
  input  logic [31:0]          rs1_data,
  input  logic [31:0]          rs2_data,
  output rv_isa_pkg::decoded_t dec,
  output rv_isa_pkg::opcode_e  opcode,
  output logic [31:0]          op_a,
  output logic [31:0]          op_b,
  output logic [31:0]          store_data
);

  logic [31:0]          ir;
  logic [`RV_XLEN-1:0]  imm_i, imm_s, imm_b;
  logic [`RV_XLEN-1:0]  imm_q;
  logic [`RV_XLEN-1:0]  rs2_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ir <= '0;
    end else if (ctrl.ir_load) begin
      ir <= instr; // held until the next fetch.
    end
  end

  assign opcode = rv_isa_pkg::opcode_e'(ir[6:0]);

  assign imm_i = {{20{ir[31]}}, ir[31:20]};
  assign imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
  assign imm_b = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};

  always_comb begin
    dec.opcode    = opcode;
    dec.rd        = ir[11:7];
    dec.rs1       = ir[19:15];
    dec.rs2       = ir[24:20];
    dec.funct7_5  = ir[30];
    dec.branch_ne = ir[12];
    case (opcode)
      rv_isa_pkg::OP_STORE:  dec.imm = imm_s;
      rv_isa_pkg::OP_BRANCH: dec.imm = imm_b;
      default:               dec.imm = imm_i;
    endcase
  end

  // operands are sampled at the end of decode.
  always_ff @(posedge clk) begin
    if (ctrl.op_load) begin
      op_a  <= rs1_data;
      rs2_q <= rs2_data;
      imm_q <= dec.imm;
    end
  end

  assign op_b       = ctrl.alu_src ? imm_q : rs2_q;
  assign store_data = rs2_q;

endmodule

//--- design/control_unit.sv
`timescale 1ns/1ps

module control_unit (
  input  logic                clk,
  input  logic                rst_n,
  input  rv_isa_pkg::opcode_e opcode,
  output rv_ctrl_pkg::ctrl_t  ctrl,
  output logic                retire
);

  rv_ctrl_pkg::state_e state, next_state;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= rv_ctrl_pkg::ST_FETCH;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = rv_ctrl_pkg::ST_FETCH;
    case (state)
      rv_ctrl_pkg::ST_FETCH: next_state = rv_ctrl_pkg::ST_DECODE;
      rv_ctrl_pkg::ST_DECODE: begin
        case (opcode)
          rv_isa_pkg::OP_IMM:    next_state = rv_ctrl_pkg::ST_EXEC_ADDI;
          rv_isa_pkg::OP_LOAD:   next_state = rv_ctrl_pkg::ST_EXEC_LOAD;
          rv_isa_pkg::OP_STORE:  next_state = rv_ctrl_pkg::ST_EXEC_STORE;
          rv_isa_pkg::OP_BRANCH: next_state = rv_ctrl_pkg::ST_EXEC_BRANCH;
          default:               next_state = rv_ctrl_pkg::ST_EXEC_ADDSUB; // r-type and unknown.
        endcase
      end
      rv_ctrl_pkg::ST_EXEC_ADDSUB,
      rv_ctrl_pkg::ST_EXEC_ADDI,
      rv_ctrl_pkg::ST_EXEC_LOAD,
      rv_ctrl_pkg::ST_EXEC_STORE,
      rv_ctrl_pkg::ST_EXEC_BRANCH: next_state = rv_ctrl_pkg::ST_WRITE_BACK;
      rv_ctrl_pkg::ST_WRITE_BACK: next_state = rv_ctrl_pkg::ST_FETCH;
      default: next_state = rv_ctrl_pkg::ST_FETCH; // illegal codes restart the sequence.
    endcase
  end

  // the control word depends on the state only.
  always_comb begin
    ctrl = '0;
    ctrl.alu_cmd = rv_isa_pkg::ALU_REG;
    retire = 1'b0;
    case (state)
      rv_ctrl_pkg::ST_FETCH:  ctrl.ir_load = 1'b1;
      rv_ctrl_pkg::ST_DECODE: ctrl.op_load = 1'b1;
      rv_ctrl_pkg::ST_EXEC_ADDSUB: begin
        ctrl.rf_we = 1'b1;
      end
      rv_ctrl_pkg::ST_EXEC_ADDI: begin
        ctrl.alu_src = 1'b1;
        ctrl.rf_we   = 1'b1;
        ctrl.alu_cmd = rv_isa_pkg::ALU_ADD;
      end
      rv_ctrl_pkg::ST_EXEC_LOAD: begin
        ctrl.alu_src = 1'b1;
        ctrl.rf_src  = 1'b1;
        ctrl.rf_we   = 1'b1;
        ctrl.alu_cmd = rv_isa_pkg::ALU_ADD;
      end
      rv_ctrl_pkg::ST_EXEC_STORE: begin
        ctrl.alu_src  = 1'b1;
        ctrl.d_mem_we = 1'b1;
        ctrl.alu_cmd  = rv_isa_pkg::ALU_ADDR;
      end
      rv_ctrl_pkg::ST_EXEC_BRANCH: begin
        ctrl.pc_src  = 1'b1;
        ctrl.alu_cmd = rv_isa_pkg::ALU_CMP;
      end
      rv_ctrl_pkg::ST_WRITE_BACK: begin
        ctrl.pc_update = 1'b1;
        retire = 1'b1;
      end
      default: ctrl.alu_cmd = rv_isa_pkg::ALU_REG;
    endcase
  end

endmodule

//--- design/rv_ctrl_pkg.sv
package rv_ctrl_pkg;

  // one pass through fetch, decode, an execute state and write-back per instruction.
  typedef enum logic [3:0] {
    ST_FETCH       = 4'd1,
    ST_DECODE      = 4'd2,
    ST_EXEC_ADDSUB = 4'd3,
    ST_EXEC_ADDI   = 4'd4,
    ST_EXEC_LOAD   = 4'd5,
    ST_EXEC_STORE  = 4'd6,
    ST_EXEC_BRANCH = 4'd7,
    ST_WRITE_BACK  = 4'd8
  } state_e;

  typedef struct packed {
    logic                 ir_load;   // capture the instruction word.
    logic                 op_load;   // latch operands and immediate.
    logic                 rf_we;
    logic                 d_mem_we;
    logic                 alu_src;   // immediate as second operand.
    logic                 rf_src;    // write back memory data.
    logic                 pc_src;    // resolve a branch this cycle.
    logic                 pc_update;
    rv_isa_pkg::alu_cmd_e alu_cmd;
  } ctrl_t;

endpackage

//--- design/rv_isa_pkg.sv
`include "rv_params.svh"

package rv_isa_pkg;

  // major opcodes of the supported RV32I subset.
  typedef enum logic [6:0] {
    OP_RTYPE  = 7'b0110011,
    OP_IMM    = 7'b0010011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_BRANCH = 7'b1100011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_REG  = 4'd0, // add or sub, chosen by funct7 bit 5.
    ALU_ADD  = 4'd1, // addi and load address.
    ALU_ADDR = 4'd2, // store address.
    ALU_CMP  = 4'd3  // subtraction for branch compare.
  } alu_cmd_e;

  typedef struct packed {
    opcode_e                opcode;
    logic [4:0]             rd;
    logic [4:0]             rs1;
    logic [4:0]             rs2;
    logic                   funct7_5;  // selects sub for r-type.
    logic                   branch_ne; // funct3 bit 0, set for bne.
    logic [`RV_XLEN-1:0]    imm;
  } decoded_t;

  typedef struct packed {
    logic                   we;
    logic [`RV_XLEN-1:0]    addr;
    logic [`RV_XLEN-1:0]    wdata;
  } dmem_req_t;

endpackage

//--- design/rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// datapath word width in bits.
`define RV_XLEN 32

// number of architectural registers, x0 included.
`define RV_NREGS 32

`define RV_RESET_PC 32'h0000_0000 // first fetch address after reset.

`endif
